// File: common/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath and register file sizes
`define DATA_WIDTH      16
`define REG_COUNT       16
`define REG_ADDR_WIDTH  4

// Instruction word layout
`define INSTR_WIDTH     24
`define OPCODE_WIDTH    8
`define OPCODE_LSB      16
`define RDEST_LSB       12
`define RSRC_LSB        8
`define IMM_WIDTH       8

// Low bits of the condition code live in the immediate field
`define COND_WIDTH      4

// Shift amount is taken from the low bits of operand B
`define SHIFT_BITS      4

`endif

// File: common/corePkg.sv
`include "core_consts.svh"

package corePkg;

	typedef logic [`DATA_WIDTH-1:0] dataWord;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes, anything not listed decodes as illegal
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [`OPCODE_WIDTH-1:0] {
		NOP    = 8'h00,
		ADD    = 8'h01,
		ADDI   = 8'h02,
		ADDU   = 8'h03,
		ADDUI  = 8'h04,
		ADDCU  = 8'h05,
		ADDCUI = 8'h06,
		SUB    = 8'h07,
		SUBI   = 8'h08,
		CMP    = 8'h09,
		CMPI   = 8'h0A,
		AND    = 8'h0B,
		OR     = 8'h0C,
		XOR    = 8'h0D,
		NOT    = 8'h0E,
		TEST   = 8'h0F,
		LSH    = 8'h10,
		LSHI   = 8'h11,
		RSH    = 8'h12,
		RSHI   = 8'h13,
		ALSH   = 8'h14,
		ARSH   = 8'h15,
		MULT   = 8'h16,
		MULTI  = 8'h17,
		MULTU  = 8'h18,
		MULTUI = 8'h19,
		MOV    = 8'h1A,
		MOVI   = 8'h1B,
		SCOND  = 8'h1C
	} aluOpcode;

	// Condition codes for SCOND, codes above AL are never true
	typedef enum logic [`COND_WIDTH-1:0] {
		EQ = 4'h0,
		NE = 4'h1,
		CS = 4'h2,
		CC = 4'h3,
		LO = 4'h4,
		HS = 4'h5,
		LT = 4'h6,
		GE = 4'h7,
		FS = 4'h8,
		FC = 4'h9,
		AL = 4'hA
	} condCode;

endpackage

// File: hw/alu/alu.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module alu (
	input  corePkg::dataWord  a,
	input  corePkg::dataWord  b,
	input  corePkg::aluOpcode opcode,
	input  logic              carryIn,
	input  logic              condMet,
	output corePkg::dataWord  c,
	output logic              carryOut,
	output logic              overflow,
	output logic              low,
	output logic              negative,
	output logic              zero
);

	import corePkg::*;

	logic                     ltSigned;
	logic                     ltUnsigned;
	logic [`SHIFT_BITS-1:0]   shAmt;
	logic [2*`DATA_WIDTH-1:0] prodU;

	assign ltSigned   = $signed(a) < $signed(b);
	assign ltUnsigned = a < b;
	assign shAmt      = b[`SHIFT_BITS-1:0];

	// Full unsigned product
	assign prodU = a * b;

	always_comb
	begin
		// Outputs an opcode does not set stay 0
		c        = '0;
		carryOut = 1'b0;
		overflow = 1'b0;
		low      = 1'b0;
		negative = 1'b0;
		zero     = 1'b0;

		case (opcode)
			////////////////////////////////////////////////////////////////////
			// Arithmetic
			////////////////////////////////////////////////////////////////////
			ADD, ADDI:
			begin
				c        = a + b;
				overflow = (a[`DATA_WIDTH-1] == b[`DATA_WIDTH-1]) &&
				           (c[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
				low      = ltSigned;
				negative = c[`DATA_WIDTH-1];
				zero     = (c == '0);
			end

			SUB, SUBI:
			begin
				c        = a - b;
				// Overflow when operand signs differ and result flips from a
				overflow = (a[`DATA_WIDTH-1] != b[`DATA_WIDTH-1]) &&
				           (c[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
				low      = ltSigned;
				negative = c[`DATA_WIDTH-1];
				zero     = (c == '0);
			end

			ADDU, ADDUI:
			begin
				{carryOut, c} = {1'b0, a} + {1'b0, b};
				low           = ltUnsigned;
				zero          = (c == '0);
			end

			ADDCU, ADDCUI:
			begin
				// Stored carry from the status register joins the sum
				{carryOut, c} = {1'b0, a} + {1'b0, b} + {{`DATA_WIDTH{1'b0}}, carryIn};
				low           = ltUnsigned;
				zero          = (c == '0);
			end

			CMP, CMPI:
			begin
				low      = ltUnsigned;
				negative = ltSigned;
				zero     = (a == b);
			end

			////////////////////////////////////////////////////////////////////
			// Logic
			////////////////////////////////////////////////////////////////////
			AND, TEST:
			begin
				c        = a & b;
				low      = ltUnsigned;
				negative = ltSigned;
				zero     = (c == '0);
			end

			OR:
			begin
				c        = a | b;
				low      = ltUnsigned;
				negative = ltSigned;
				zero     = (c == '0);
			end

			XOR:
			begin
				c        = a ^ b;
				low      = ltUnsigned;
				negative = ltSigned;
				zero     = (c == '0);
			end

			NOT:
			begin
				c        = ~a;
				low      = ltUnsigned;
				negative = ltSigned;
				zero     = (c == '0);
			end

			// Shifts only report Zero
			LSH, LSHI, ALSH:
			begin
				c    = a << shAmt;
				zero = (c == '0);
			end

			RSH, RSHI:
			begin
				c    = a >> shAmt;
				zero = (c == '0);
			end

			ARSH:
			begin
				c    = $signed(a) >>> shAmt;
				zero = (c == '0);
			end

			// Low word of the product is the same signed or unsigned
			MULT, MULTI, MULTU, MULTUI:
			begin
				c    = prodU[`DATA_WIDTH-1:0];
				zero = (c == '0);
			end

			MOV, MOVI:
			begin
				c    = b;
				zero = (c == '0);
			end

			SCOND:
			begin
				c    = {{(`DATA_WIDTH-1){1'b0}}, condMet};
				zero = ~condMet;
			end

			// NOP and illegal opcodes keep the cleared values
			default:
			begin
				c = '0;
			end
		endcase
	end

endmodule

// File: hw/alu/statusReg.sv
`timescale 1ns/1ps

module statusReg (
	input  logic             clk,
	input  logic             rst,
	input  logic             flagsWrite,
	input  logic             nextCarry,
	input  logic             nextFlag,
	input  logic             nextLow,
	input  logic             nextNegative,
	input  logic             nextZero,
	input  corePkg::condCode condSel,
	output logic             carry,
	output logic             flag,
	output logic             low,
	output logic             negative,
	output logic             zero,
	output logic             carryStored,
	output logic             condMet
);

	import corePkg::*;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			carry    <= 1'b0;
			flag     <= 1'b0;
			low      <= 1'b0;
			negative <= 1'b0;
			zero     <= 1'b0;
		end
		else if (flagsWrite)
		begin
			carry    <= nextCarry;
			flag     <= nextFlag;
			low      <= nextLow;
			negative <= nextNegative;
			zero     <= nextZero;
		end
	end

	// Feedback path for ADDCU and ADDCUI
	assign carryStored = carry;

	// Condition test against the stored flags
	always_comb
	begin
		case (condSel)
			EQ:      condMet = zero;
			NE:      condMet = ~zero;
			CS:      condMet = carry;
			CC:      condMet = ~carry;
			LO:      condMet = low;
			HS:      condMet = ~low;
			LT:      condMet = negative;
			GE:      condMet = ~negative;
			FS:      condMet = flag;
			FC:      condMet = ~flag;
			AL:      condMet = 1'b1;
			default: condMet = 1'b0;
		endcase
	end

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module regFile (
	input  logic             clk,
	input  logic             rst,
	input  corePkg::regAddr  readAddrA,
	input  corePkg::regAddr  readAddrB,
	input  corePkg::regAddr  writeAddr,
	input  corePkg::dataWord writeData,
	input  logic             writeEnable,
	output corePkg::dataWord readDataA,
	output corePkg::dataWord readDataB
);

	import corePkg::*;

	dataWord regs [`REG_COUNT];

	// Single write port
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEnable)
		begin
			regs[writeAddr] <= writeData;
		end
	end

	// Asynchronous reads, a write shows up after the edge
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

// File: hw/instrDecoder.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module instrDecoder (
	input  logic [`INSTR_WIDTH-1:0] instr,
	input  logic                    instrValid,
	input  corePkg::dataWord        readDataB,
	output corePkg::aluOpcode       opcode,
	output corePkg::regAddr         rDest,
	output corePkg::regAddr         rSrc,
	output corePkg::condCode        condSel,
	output corePkg::dataWord        operandB,
	output logic                    regWrite,
	output logic                    flagsWrite,
	output logic                    illegalOp
);

	import corePkg::*;

	logic [`IMM_WIDTH-1:0] imm;
	dataWord               immExt;
	logic                  operandSel;
	logic                  signExt;
	logic                  writesReg;
	logic                  writesFlags;
	logic                  legal;

	////////////////////////////////////////////////////////////////////////////
	// Field split
	////////////////////////////////////////////////////////////////////////////
	assign opcode  = aluOpcode'(instr[`OPCODE_LSB +: `OPCODE_WIDTH]);
	assign rDest   = instr[`RDEST_LSB +: `REG_ADDR_WIDTH];
	assign rSrc    = instr[`RSRC_LSB +: `REG_ADDR_WIDTH];
	assign imm     = instr[`IMM_WIDTH-1:0];
	// SCOND carries its condition in the low immediate bits
	assign condSel = condCode'(imm[`COND_WIDTH-1:0]);

	// Opcode classes
	always_comb
	begin
		operandSel  = 1'b0;
		signExt     = 1'b0;
		writesReg   = 1'b0;
		writesFlags = 1'b0;
		legal       = 1'b1;

		case (opcode)
			NOP:
			begin
				legal = 1'b1;
			end
			ADD, ADDU, ADDCU, SUB, AND, OR, XOR, NOT,
			LSH, RSH, ALSH, ARSH, MULT, MULTU:
			begin
				writesReg   = 1'b1;
				writesFlags = 1'b1;
			end
			ADDI, SUBI, MULTI:
			begin
				operandSel  = 1'b1;
				signExt     = 1'b1;
				writesReg   = 1'b1;
				writesFlags = 1'b1;
			end
			ADDUI, ADDCUI, LSHI, RSHI, MULTUI:
			begin
				operandSel  = 1'b1;
				writesReg   = 1'b1;
				writesFlags = 1'b1;
			end
			CMP, TEST:
			begin
				writesFlags = 1'b1;
			end
			CMPI:
			begin
				operandSel  = 1'b1;
				signExt     = 1'b1;
				writesFlags = 1'b1;
			end
			MOV, SCOND:
			begin
				writesReg = 1'b1;
			end
			MOVI:
			begin
				operandSel = 1'b1;
				signExt    = 1'b1;
				writesReg  = 1'b1;
			end
			default:
			begin
				legal = 1'b0;
			end
		endcase
	end

	assign immExt   = signExt ? {{(`DATA_WIDTH-`IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm}
	                          : {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, imm};
	assign operandB = operandSel ? immExt : readDataB;

	// Illegal opcodes never enable a write
	assign regWrite   = instrValid & writesReg;
	assign flagsWrite = instrValid & writesFlags;
	assign illegalOp  = instrValid & ~legal;

endmodule

// File: hw/execCore.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module execCore (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    instrValid,
	input  logic [`INSTR_WIDTH-1:0] instr,
	output corePkg::dataWord        result,
	output logic                    resultValid,
	output logic                    illegal,
	output logic                    carry,
	output logic                    flag,
	output logic                    low,
	output logic                    negative,
	output logic                    zero
);

	import corePkg::*;

	aluOpcode opcode;
	condCode  condSel;
	regAddr   rDest;
	regAddr   rSrc;
	dataWord  readDataA;
	dataWord  readDataB;
	dataWord  operandB;
	dataWord  aluResult;
	logic     regWrite;
	logic     flagsWrite;
	logic     illegalOp;
	logic     carryStored;
	logic     condMet;
	logic     aluCarry;
	logic     aluOverflow;
	logic     aluLow;
	logic     aluNegative;
	logic     aluZero;

	instrDecoder decoder (
		.instr      (instr),
		.instrValid (instrValid),
		.readDataB  (readDataB),
		.opcode     (opcode),
		.rDest      (rDest),
		.rSrc       (rSrc),
		.condSel    (condSel),
		.operandB   (operandB),
		.regWrite   (regWrite),
		.flagsWrite (flagsWrite),
		.illegalOp  (illegalOp)
	);

	// Operand A is always the destination register
	regFile registers (
		.clk         (clk),
		.rst         (rst),
		.readAddrA   (rDest),
		.readAddrB   (rSrc),
		.writeAddr   (rDest),
		.writeData   (aluResult),
		.writeEnable (regWrite),
		.readDataA   (readDataA),
		.readDataB   (readDataB)
	);

	alu aluUnit (
		.a        (readDataA),
		.b        (operandB),
		.opcode   (opcode),
		.carryIn  (carryStored),
		.condMet  (condMet),
		.c        (aluResult),
		.carryOut (aluCarry),
		.overflow (aluOverflow),
		.low      (aluLow),
		.negative (aluNegative),
		.zero     (aluZero)
	);

	statusReg status (
		.clk          (clk),
		.rst          (rst),
		.flagsWrite   (flagsWrite),
		.nextCarry    (aluCarry),
		.nextFlag     (aluOverflow),
		.nextLow      (aluLow),
		.nextNegative (aluNegative),
		.nextZero     (aluZero),
		.condSel      (condSel),
		.carry        (carry),
		.flag         (flag),
		.low          (low),
		.negative     (negative),
		.zero         (zero),
		.carryStored  (carryStored),
		.condMet      (condMet)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output registers, loaded on the same edge as the writeback
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result      <= '0;
			resultValid <= 1'b0;
			illegal     <= 1'b0;
		end
		else
		begin
			resultValid <= instrValid;
			illegal     <= illegalOp;
			if (instrValid)
			begin
				result <= aluResult;
			end
		end
	end

endmodule

// File: verif/tbExecCore.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module tbExecCore;

	import corePkg::*;

	localparam int TIMEOUT_CYCLES = 20;
	localparam int MAX_LINES      = 1000;

	logic                    clk;
	logic                    rst;
	logic                    instrValid;
	logic [`INSTR_WIDTH-1:0] instr;
	dataWord                 result;
	logic                    resultValid;
	logic                    illegal;
	logic                    carry;
	logic                    flag;
	logic                    low;
	logic                    negative;
	logic                    zero;

	int wordErrors;
	int flagErrors;
	int illegalErrors;
	int validErrors;
	int timeouts;
	int fileErrors;
	int caseCount;
	int totalErrors;
	int seed;
	int dummy;
	int fd;
	int fields;
	int linesRead;
	logic [8*160-1:0]        lineBuf;
	logic [`INSTR_WIDTH-1:0] caseInstr;
	dataWord                 expResult;
	logic [4:0]              expFlags;
	logic                    expIllegal;

	execCore uut (
		.clk         (clk),
		.rst         (rst),
		.instrValid  (instrValid),
		.instr       (instr),
		.result      (result),
		.resultValid (resultValid),
		.illegal     (illegal),
		.carry       (carry),
		.flag        (flag),
		.low         (low),
		.negative    (negative),
		.zero        (zero)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic checkWord(input dataWord got, input dataWord exp,
		input logic [`INSTR_WIDTH-1:0] word);
		if (got !== exp)
		begin
			$display("error at %0t ns: instr %h result %h, expected %h",
				$time, word, got, exp);
			wordErrors++;
		end
	endtask

	// Flag order is carry, flag, low, negative, zero
	task automatic checkFlags(input logic [4:0] got, input logic [4:0] exp,
		input logic [`INSTR_WIDTH-1:0] word);
		if (got !== exp)
		begin
			$display("error at %0t ns: instr %h flags %b, expected %b",
				$time, word, got, exp);
			flagErrors++;
		end
	endtask

	task automatic checkIllegal(input logic got, input logic exp,
		input logic [`INSTR_WIDTH-1:0] word);
		if (got !== exp)
		begin
			$display("error at %0t ns: instr %h illegal %b, expected %b",
				$time, word, got, exp);
			illegalErrors++;
		end
	endtask

	task automatic checkValid(input logic got, input logic exp,
		input logic [`INSTR_WIDTH-1:0] word);
		if (got !== exp)
		begin
			$display("error at %0t ns: instr %h resultValid %b, expected %b",
				$time, word, got, exp);
			validErrors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////
	// One-cycle strobe from falling edge to falling edge
	task automatic applyInstr(input logic [`INSTR_WIDTH-1:0] word);
		instr      = word;
		instrValid = 1'b1;
		@(negedge clk);
		instrValid = 1'b0;
	endtask

	task automatic waitResult(output bit seen);
		int cycles;
		cycles = 0;
		while (resultValid !== 1'b1 && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			cycles++;
		end
		seen = (resultValid === 1'b1);
	endtask

	task automatic runCase(input logic [`INSTR_WIDTH-1:0] word, input dataWord wantResult,
		input logic [4:0] wantFlags, input logic wantIllegal);
		bit seen;
		int idle;
		applyInstr(word);
		waitResult(seen);
		if (!seen)
		begin
			$display("Timed out: resultValid never came for instruction %h", word);
			timeouts++;
		end
		else
		begin
			checkWord(result, wantResult, word);
			checkFlags({carry, flag, low, negative, zero}, wantFlags, word);
			checkIllegal(illegal, wantIllegal, word);
		end
		// Random gap so back-to-back and spaced strobes both occur
		idle = $urandom % 4;
		repeat (idle)
		begin
			@(negedge clk);
			// Both pulses last a single cycle
			checkValid(resultValid, 1'b0, word);
			checkIllegal(illegal, 1'b0, word);
		end
	endtask

	initial
	begin
		clk           = 1'b0;
		rst           = 1'b1;
		instrValid    = 1'b0;
		instr         = '0;
		wordErrors    = 0;
		flagErrors    = 0;
		illegalErrors = 0;
		validErrors   = 0;
		timeouts      = 0;
		fileErrors    = 0;
		caseCount     = 0;
		linesRead     = 0;
		seed          = 44;
		dummy         = $urandom(seed);

		repeat (10) @(negedge clk);
		rst = 1'b0;

		fd = $fopen("verif/alu_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the cases file verif/alu_cases.txt");
			fileErrors++;
		end
		else
		begin
			while (!$feof(fd) && linesRead < MAX_LINES)
			begin
				fields = $fscanf(fd, "%h %h %b %b\n", caseInstr, expResult, expFlags,
					expIllegal);
				if (fields == 4)
				begin
					caseCount++;
					runCase(caseInstr, expResult, expFlags, expIllegal);
				end
				else
				begin
					// Comment or blank line
					dummy = $fgets(lineBuf, fd);
				end
				linesRead++;
			end
			$fclose(fd);
		end

		if (caseCount == 0)
		begin
			$display("No test cases were read from the cases file");
			fileErrors++;
		end

		totalErrors = wordErrors + flagErrors + illegalErrors + validErrors + timeouts +
			fileErrors;
		$display("Cases %0d errors: result %0d flags %0d illegal %0d valid %0d timeout %0d",
			caseCount, wordErrors, flagErrors, illegalErrors, validErrors, timeouts);
		if (totalErrors == 0)
		begin
			$display("Simulation PASSED");
		end
		else
		begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: verif/alu_cases.txt
# One instruction per line, instruction word and expected result in hex,
# then flags as carry flag low negative zero in binary, then the illegal bit
# Register loading
1B1005 0005 00000 0
1B2080 FF80 00000 0
1B307F 007F 00000 0
1A4200 FF80 00000 0
# Signed add and subtract
1B507F 007F 00000 0
115008 7F00 00000 0
015500 FE00 01010 0
1B6080 FF80 01010 0
116008 8000 00000 0
086001 7FFF 01100 0
026001 8000 01010 0
071300 FF86 00110 0
# Unsigned add and carry chain
044090 0010 10000 0
053100 0006 10100 0
067000 0001 00000 0
037300 0007 00100 0
# Compare keeps the destination
0A7007 0000 00001 0
093100 0000 00100 0
0A1010 0000 00010 0
1A8100 FF86 00010 0
# Logic
0B2300 0000 00011 0
0C2100 FF86 00100 0
0D2800 0000 00001 0
0E2300 FFFF 00110 0
0F7400 0000 00111 0
# Shifts by the low 4 bits of 0x13
1B9013 0013 00111 0
108900 FC30 00000 0
158900 FF86 00000 0
138014 0FF8 00000 0
142900 FFF8 00000 0
116011 0000 00001 0
155900 FFC0 00000 0
# Multiply
165300 FE80 00000 0
1730FE FFF4 00000 0
182200 0040 00000 0
196025 0000 00001 0
197080 0380 00000 0
# Conditions with only Negative set
0A5010 0000 00010 0
1CB000 0000 00010 0
1CB001 0001 00010 0
1CB004 0000 00010 0
1CB005 0001 00010 0
1CB006 0001 00010 0
1CB007 0000 00010 0
1CB00A 0001 00010 0
1CB00B 0000 00010 0
# Conditions with Carry set
035500 FD00 10000 0
1CB002 0001 10000 0
1CB003 0000 10000 0
# Signed overflow with a zero result
1BC080 FF80 10000 0
11C008 8000 00000 0
01CC00 0000 01001 0
1CB008 0001 01001 0
1CB009 0000 01001 0
# Illegal opcodes and NOP
3F1123 0000 01001 1
FF35AA 0000 01001 1
1D2000 0000 01001 1
001234 0000 01001 0
1AD100 FF86 01001 0
1AE300 FFF4 01001 0
1CB008 0001 01001 0

// File: flist.f
+incdir+common
common/corePkg.sv
hw/alu/alu.sv
hw/alu/statusReg.sv
hw/regFile.sv
hw/instrDecoder.sv
hw/execCore.sv
verif/tbExecCore.sv
